/* flist.f */
hdl/afifo_pkg.sv
hdl/bit_sync.sv
hdl/async_fifo.sv
hdl/afifo_chain.sv
hdl/afifo_chain_top.sv
test/tb_afifo_chain.sv

/* hdl/afifo_chain.sv */
module afifo_chain #(
    parameter int STAGES   = afifo_pkg::DEF_STAGES,    // FIFOs in series
    parameter int DEPTH    = afifo_pkg::DEF_DEPTH,     // Words per FIFO
    parameter int W_THRESH = STAGES / 2,               // Stage count checked for room
    parameter int R_THRESH = STAGES / 2                // Stage count checked for fill
) (
    input  logic                   rst,
    input  logic                   prop_clk,     // Fastest clock, moves words between stages

    // Write side
    input  logic                   w_clk,
    input  logic                   w_trigger,
    input  afifo_pkg::chain_word_t w_data,
    output logic                   w_ready,
    output logic                   w_thresh,     // Front stages have room

    // Read side
    input  logic                   r_clk,
    input  logic                   r_trigger,
    output afifo_pkg::chain_word_t r_data,
    output logic                   r_ready,
    output logic                   r_thresh      // Back stages have filled up
);

    // Stage outputs, one element per FIFO
    logic                   stage_w_ready [STAGES];
    logic                   stage_r_ready [STAGES];
    afifo_pkg::chain_word_t stage_r_data  [STAGES];

    // ************************************************
    // FIFO stages
    // ************************************************

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        logic                   stage_w_clk;
        logic                   stage_w_trigger;
        afifo_pkg::chain_word_t stage_w_data;
        logic                   stage_r_clk;
        logic                   stage_r_trigger;

        // Write port comes from outside for the head, else from the previous stage
        if (i == 0) begin : g_head
            assign stage_w_clk     = w_clk;
            assign stage_w_trigger = w_trigger;
            assign stage_w_data    = w_data;
        end else begin : g_link_in
            assign stage_w_clk     = prop_clk;
            assign stage_w_trigger = stage_r_ready[i-1];    // Upstream has a word
            assign stage_w_data    = stage_r_data[i-1];
        end

        // Read port goes outside for the tail, else into the next stage
        if (i == STAGES - 1) begin : g_tail
            assign stage_r_clk     = r_clk;
            assign stage_r_trigger = r_trigger;
        end else begin : g_link_out
            assign stage_r_clk     = prop_clk;
            assign stage_r_trigger = stage_w_ready[i+1];    // Downstream has room
        end

        async_fifo #(
            .DEPTH(DEPTH)
        ) u_fifo (
            .rst      (rst),
            .w_clk    (stage_w_clk),
            .w_trigger(stage_w_trigger),
            .w_data   (stage_w_data),
            .w_ready  (stage_w_ready[i]),
            .r_clk    (stage_r_clk),
            .r_trigger(stage_r_trigger),
            .r_data   (stage_r_data[i]),
            .r_ready  (stage_r_ready[i])
        );
    end

    // Between two stages both FIFOs see the same prop_clk edge and the same
    // pair of flags, so each transfer is a pop upstream and a push downstream

    assign w_ready = stage_w_ready[0];
    assign r_ready = stage_r_ready[STAGES-1];
    assign r_data  = stage_r_data[STAGES-1];

    // ************************************************
    // Fill-level hints
    // ************************************************

    localparam int W_IDX = W_THRESH - 1;         // Stage whose emptiness means room
    localparam int R_IDX = STAGES - R_THRESH;    // Stage whose fullness means backlog

    logic w_thresh_async;    // Raw flag in that stage's own domain
    logic r_thresh_async;

    assign w_thresh_async = !stage_r_ready[W_IDX];    // Stage shows no data
    assign r_thresh_async = !stage_w_ready[R_IDX];    // Stage is full

    bit_sync #(
        .WIDTH(1)
    ) u_w_thresh_sync (
        .clk     (w_clk),
        .rst     (rst),
        .async_in(w_thresh_async),
        .sync_out(w_thresh)
    );

    bit_sync #(
        .WIDTH(1)
    ) u_r_thresh_sync (
        .clk     (r_clk),
        .rst     (rst),
        .async_in(r_thresh_async),
        .sync_out(r_thresh)
    );

endmodule

/* hdl/afifo_chain_top.sv */
module afifo_chain_top #(
    parameter int STAGES   = afifo_pkg::DEF_STAGES,
    parameter int DEPTH    = afifo_pkg::DEF_DEPTH,
    parameter int W_THRESH = STAGES / 2,    // Half the stages empty raises w_thresh
    parameter int R_THRESH = STAGES / 2     // Half the stages full raises r_thresh
) (
    input  logic                   rst,
    input  logic                   prop_clk,

    // Write side
    input  logic                   w_clk,
    input  logic                   w_trigger,
    input  afifo_pkg::chain_word_t w_data,
    output logic                   w_ready,
    output logic                   w_thresh,

    // Read side
    input  logic                   r_clk,
    input  logic                   r_trigger,
    output afifo_pkg::chain_word_t r_data,
    output logic                   r_ready,
    output logic                   r_thresh
);

    // ************************************************
    // Crossing chain
    // ************************************************

    afifo_chain #(
        .STAGES  (STAGES),
        .DEPTH   (DEPTH),
        .W_THRESH(W_THRESH),
        .R_THRESH(R_THRESH)
    ) u_chain (
        .rst      (rst),
        .prop_clk (prop_clk),
        .w_clk    (w_clk),
        .w_trigger(w_trigger),
        .w_data   (w_data),
        .w_ready  (w_ready),
        .w_thresh (w_thresh),
        .r_clk    (r_clk),
        .r_trigger(r_trigger),
        .r_data   (r_data),
        .r_ready  (r_ready),
        .r_thresh (r_thresh)
    );

endmodule

/* hdl/afifo_pkg.sv */
package afifo_pkg;

    // ************************************************
    // Word format carried through the chain
    // ************************************************

    localparam int TAG_BITS     = 4;     // Low bits of the sequence number
    localparam int PAYLOAD_BITS = 12;    // Data bits per word

    typedef struct packed {
        logic [TAG_BITS-1:0]     tag;        // Sequence tag, checked for ordering
        logic [PAYLOAD_BITS-1:0] payload;    // User data
    } chain_word_t;

    localparam int WORD_BITS = $bits(chain_word_t);    // Memory word width, 16

    // ************************************************
    // Default chain sizing
    // ************************************************

    localparam int DEF_STAGES = 4;    // FIFOs in the chain
    localparam int DEF_DEPTH  = 8;    // Words per FIFO, must be a power of two

endpackage

/* hdl/async_fifo.sv */
module async_fifo #(
    parameter int DEPTH = afifo_pkg::DEF_DEPTH    // Words held, power of two
) (
    input  logic                   rst,

    // Write side
    input  logic                   w_clk,
    input  logic                   w_trigger,
    input  afifo_pkg::chain_word_t w_data,
    output logic                   w_ready,

    // Read side
    input  logic                   r_clk,
    input  logic                   r_trigger,
    output afifo_pkg::chain_word_t r_data,
    output logic                   r_ready
);

    localparam int ADDR_BITS = $clog2(DEPTH);    // Memory address width
    localparam int PTR_BITS  = ADDR_BITS + 1;    // Extra bit tells a wrap from equal

    // Flips the two top Gray bits of the read pointer to form the full pattern
    localparam logic [PTR_BITS-1:0] FULL_MASK = PTR_BITS'(3) << (PTR_BITS - 2);

    // Binary to reflected Gray code
    function automatic logic [PTR_BITS-1:0] bin_to_gray(input logic [PTR_BITS-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // ************************************************
    // Storage
    // ************************************************

    logic [afifo_pkg::WORD_BITS-1:0] mem [DEPTH];    // Written on w_clk, read on r_clk

    // ************************************************
    // Write domain
    // ************************************************

    logic [PTR_BITS-1:0] w_bin;           // Write pointer, binary
    logic [PTR_BITS-1:0] w_bin_next;      // Pointer after the current write
    logic [PTR_BITS-1:0] w_gray;          // Write pointer, Gray, sent to r_clk
    logic [PTR_BITS-1:0] r_gray_wsync;    // Read pointer seen in w_clk
    logic                w_fire;          // A write is taken on this edge
    logic                full;

    assign w_bin_next = w_bin + PTR_BITS'(1);
    assign w_fire     = w_trigger && w_ready;    // Triggers while full are dropped here

    always_ff @(posedge w_clk) begin
        if (rst) begin
            w_bin  <= '0;
            w_gray <= '0;
        end else if (w_fire) begin
            w_bin  <= w_bin_next;
            w_gray <= bin_to_gray(w_bin_next);
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_fire) begin
            mem[w_bin[ADDR_BITS-1:0]] <= w_data;
        end
    end

    // Full when the writer sits one lap ahead of the synchronized reader.
    // Because w_gray is compared as registered, w_ready drops right after
    // the edge that fills the last slot
    assign full    = (w_gray == (r_gray_wsync ^ FULL_MASK));
    assign w_ready = !full;

    // ************************************************
    // Read domain
    // ************************************************

    logic [PTR_BITS-1:0] r_bin;           // Read pointer, binary
    logic [PTR_BITS-1:0] r_bin_next;      // Pointer after the current pop
    logic [PTR_BITS-1:0] r_gray;          // Read pointer, Gray, sent to w_clk
    logic [PTR_BITS-1:0] w_gray_rsync;    // Write pointer seen in r_clk
    logic                r_fire;          // A pop happens on this edge
    logic                empty;

    assign r_bin_next = r_bin + PTR_BITS'(1);
    assign r_fire     = r_trigger && r_ready;    // Pops while empty are dropped here

    always_ff @(posedge r_clk) begin
        if (rst) begin
            r_bin  <= '0;
            r_gray <= '0;
        end else if (r_fire) begin
            r_bin  <= r_bin_next;
            r_gray <= bin_to_gray(r_bin_next);
        end
    end

    // Read pointer goes back to w_clk for the full test
    bit_sync #(
        .WIDTH(PTR_BITS)
    ) u_r_ptr_sync (
        .clk     (w_clk),
        .rst     (rst),
        .async_in(r_gray),
        .sync_out(r_gray_wsync)
    );

    // New words show up here two to three r_clk edges after their write
    assign empty   = (r_gray == w_gray_rsync);
    assign r_ready = !empty;

    // Head word falls through, valid whenever r_ready is high
    assign r_data = afifo_pkg::chain_word_t'(mem[r_bin[ADDR_BITS-1:0]]);

    bit_sync #(
        .WIDTH(PTR_BITS)
    ) u_w_ptr_sync (
        .clk     (r_clk),
        .rst     (rst),
        .async_in(w_gray),
        .sync_out(w_gray_rsync)
    );

endmodule

/* hdl/bit_sync.sv */
module bit_sync #(
    parameter int WIDTH = 1    // Bits carried, Gray-coded when wider than one
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] async_in,
    output logic [WIDTH-1:0] sync_out
);

    // First rank may go metastable, the second gives it a full cycle to settle
    logic [WIDTH-1:0] meta;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta     <= '0;
            sync_out <= '0;
        end else begin
            meta     <= async_in;    // Sampled from the foreign clock domain
            sync_out <= meta;        // Stable copy for local logic
        end
    end

endmodule

/* test/chain_tests.txt */
# step count w_throttle_pct r_throttle_pct w_ready w_thresh r_thresh
# Throttle is the percentage of cycles a side holds its trigger low
reset  0  0  0  1 1 0

# Plain streaming, both sides always offering
stream 40 0  0  1 1 0
stream 24 0  0  1 1 0

# Back-pressure until all 32 slots hold data, then empty it again
fill   32 0  0  0 0 1
drain  32 0  0  1 1 0

# Throttled traffic on both sides
random 60 30 20 1 1 0
random 60 10 60 1 1 0
random 60 60 10 1 1 0
random 80 50 50 1 1 0

# Fill with a slow writer, drain with a slow reader
fill   32 40 0  0 0 1
drain  32 0  50 1 1 0

# Reader far slower than writer
random 48 25 75 1 1 0
random 36 0  80 1 1 0

# Writer far slower than reader
random 36 80 0  1 1 0

# Another full cycle of the chain
fill   32 0  0  0 0 1
drain  32 0  20 1 1 0
stream 16 0  0  1 1 0
random 50 45 45 1 1 0
fill   32 20 0  0 0 1
drain  32 0  0  1 1 0
stream 12 0  0  1 1 0

/* test/tb_afifo_chain.sv */
module tb_afifo_chain;

    timeunit 1ns;
    timeprecision 100ps;

    localparam string TEST_FILE = "test/chain_tests.txt";
    localparam int    W_PERIOD  = 40;    // w_clk period in ns
    localparam int    SETTLE    = 64;    // Quiet cycles before flags are checked

    logic                   rst       = 1'b1;
    logic                   w_clk     = 1'b0;
    logic                   r_clk     = 1'b0;
    logic                   prop_clk  = 1'b0;
    logic                   w_trigger = 1'b0;
    afifo_pkg::chain_word_t w_data    = '0;
    logic                   r_trigger = 1'b0;
    logic                   w_ready;
    logic                   w_thresh;
    afifo_pkg::chain_word_t r_data;
    logic                   r_ready;
    logic                   r_thresh;

    integer                 seed = 28469;    // Shared by both throttles
    int unsigned            seq  = 0;        // Running word counter
    afifo_pkg::chain_word_t expected_q [$];  // Accepted words still in flight

    // Step table loaded from the test file
    string step_name    [$];
    int    step_count   [$];
    int    step_w_pct   [$];
    int    step_r_pct   [$];
    int    exp_w_ready  [$];
    int    exp_w_thresh [$];
    int    exp_r_thresh [$];

    always #20 w_clk = ~w_clk;          // 40 ns
    always #26 r_clk = ~r_clk;          // 52 ns
    always #10 prop_clk = ~prop_clk;    // 20 ns, fastest of the three

    afifo_chain_top dut (
        .rst      (rst),
        .prop_clk (prop_clk),
        .w_clk    (w_clk),
        .w_trigger(w_trigger),
        .w_data   (w_data),
        .w_ready  (w_ready),
        .w_thresh (w_thresh),
        .r_clk    (r_clk),
        .r_trigger(r_trigger),
        .r_data   (r_data),
        .r_ready  (r_ready),
        .r_thresh (r_thresh)
    );

    // ************************************************
    // Helpers
    // ************************************************

    task automatic stop_run(input string msg);
        $display("Error: %s", msg);
        $display("TEST FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic afifo_pkg::chain_word_t make_word(input int unsigned n);
        afifo_pkg::chain_word_t word;
        word.tag     = n[afifo_pkg::TAG_BITS-1:0];        // Low bits of the sequence
        word.payload = n[afifo_pkg::PAYLOAD_BITS-1:0];
        return word;
    endfunction

    // High means the side offers a transfer this cycle
    function automatic logic pick_trigger(input int pct);
        int roll;
        roll = ($random(seed) & 32'h7fff_ffff) % 100;
        return roll >= pct;
    endfunction

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    n;
        string name;
        int    cnt;
        int    wp;
        int    rp;
        int    ewr;
        int    ewt;
        int    ert;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            stop_run("cannot open the test file test/chain_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", name);
                if (n == 1 && name[0] == "#") begin
                    skip_line(fd);    // Column notes
                end else if (n == 1) begin
                    n = $fscanf(fd, "%d %d %d %d %d %d", cnt, wp, rp, ewr, ewt, ert);
                    if (n != 6) begin
                        stop_run({"missing fields on test line ", name});
                    end else begin
                        step_name.push_back(name);
                        step_count.push_back(cnt);
                        step_w_pct.push_back(wp);
                        step_r_pct.push_back(rp);
                        exp_w_ready.push_back(ewr);
                        exp_w_thresh.push_back(ewt);
                        exp_r_thresh.push_back(ert);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ************************************************
    // Traffic
    // ************************************************

    task automatic write_words(input int count, input int pct);
        int sent;
        sent = 0;
        @(posedge w_clk);
        w_data    <= make_word(seq);
        w_trigger <= pick_trigger(pct);
        while (sent < count) begin
            @(posedge w_clk);
            if (w_trigger && w_ready) begin    // Taken on this edge
                expected_q.push_back(w_data);
                seq++;
                sent++;
            end
            if (sent < count) begin
                w_data    <= make_word(seq);
                w_trigger <= pick_trigger(pct);
            end else begin
                w_trigger <= 1'b0;
            end
        end
    endtask

    task automatic read_words(input int count, input int pct);
        int                     got;
        afifo_pkg::chain_word_t exp_word;
        got = 0;
        @(posedge r_clk);
        r_trigger <= pick_trigger(pct);
        while (got < count) begin
            @(posedge r_clk);
            if (r_trigger && r_ready) begin    // Head word popped on this edge
                if (expected_q.size() == 0) begin
                    stop_run("the chain returned a word that was never written");
                end else begin
                    exp_word = expected_q.pop_front();
                    check_value("r_data.tag", r_data.tag, exp_word.tag);
                    check_value("r_data.payload", r_data.payload, exp_word.payload);
                    got++;
                end
            end
            if (got < count) begin
                r_trigger <= pick_trigger(pct);
            end else begin
                r_trigger <= 1'b0;
            end
        end
    endtask

    // Offers words until w_ready has stayed low for SETTLE cycles
    task automatic fill_chain(input int count, input int pct);
        int accepted;
        int low_run;
        accepted = 0;
        low_run  = 0;
        @(posedge w_clk);
        w_data    <= make_word(seq);
        w_trigger <= pick_trigger(pct);
        while (low_run < SETTLE) begin
            @(posedge w_clk);
            if (w_trigger && w_ready) begin
                expected_q.push_back(w_data);
                seq++;
                accepted++;
            end
            low_run = w_ready ? 0 : low_run + 1;
            w_data    <= make_word(seq);
            w_trigger <= pick_trigger(pct);
        end
        w_trigger <= 1'b0;
        check_value("accepted words", accepted, count);
    endtask

    task automatic check_flags(input int idx);
        @(posedge w_clk);
        check_value("w_ready", w_ready, exp_w_ready[idx]);
        check_value("w_thresh", w_thresh, exp_w_thresh[idx]);
        @(posedge r_clk);
        check_value("r_thresh", r_thresh, exp_r_thresh[idx]);
        check_value("r_ready", r_ready, expected_q.size() != 0);    // High while words wait
    endtask

    task automatic run_step(input int idx);
        if (step_name[idx] == "reset") begin
            @(posedge w_clk);
            check_value("w_ready", w_ready, 1);
            check_value("r_ready", r_ready, 0);
            repeat (4) @(posedge w_clk);
            repeat (4) @(posedge r_clk);
            check_flags(idx);
        end else if (step_name[idx] == "fill") begin
            fill_chain(step_count[idx], step_w_pct[idx]);
            check_flags(idx);
        end else if (step_name[idx] == "drain") begin
            read_words(step_count[idx], step_r_pct[idx]);
            repeat (SETTLE) @(posedge r_clk);
            check_flags(idx);
        end else if (step_name[idx] == "stream" || step_name[idx] == "random") begin
            fork
                write_words(step_count[idx], step_w_pct[idx]);
                read_words(step_count[idx], step_r_pct[idx]);
            join
            repeat (SETTLE) @(posedge r_clk);
            check_flags(idx);
        end else begin
            stop_run({"unknown step name ", step_name[idx]});
        end
    endtask

    // ************************************************
    // Main sequence and watchdog
    // ************************************************

    initial begin
        int     total_words;
        longint hang_ns;
        load_tests();
        total_words = 0;
        foreach (step_count[i]) begin
            total_words += step_count[i];
        end
        hang_ns = longint'(total_words) * 64 * W_PERIOD + 2000;
        fork
            begin
                #(hang_ns);
                $display("Error: the run hung and did not finish within %0d ns", hang_ns);
                $display("TEST FAILED");
                $fatal(1, "Watchdog expired");
            end
        join_none
        repeat (16) @(posedge w_clk);
        rst <= 1'b0;
        foreach (step_name[i]) begin
            $display("Step %0d: %s with %0d words", i, step_name[i], step_count[i]);
            run_step(i);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule
